//--- filelist.f
src/spw_tx_pkg.sv
src/char_if.sv
src/char_scheduler.sv
src/char_serializer.sv
src/spw_tx.sv
testbench/spw_tx_chk.sv
testbench/spw_tx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the transmitter testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module spw_tx_tb -f filelist.f

status=0
./obj_dir/Vspw_tx_tb +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Something failed" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Everything OK" sim.log; then
	echo "Simulation did not complete"
	exit 1
fi
echo "Simulation passed"

//--- src/char_if.sv
// Character handoff bus
`timescale 1ns/10ps
`default_nettype none

interface char_if;
	import spw_tx_pkg::*;

	// One-cycle request to start a new character
	logic load;
	char_kind_t kind;
	// Data byte or time value
	byte_t payload;
	// Final bit of the current character is on the wire
	logic last_bit;

	modport scheduler
	(
		output load,
		output kind,
		output payload,
		input last_bit
	);

	modport serializer
	(
		input load,
		input kind,
		input payload,
		output last_bit
	);

endinterface

`default_nettype wire

//--- src/char_scheduler.sv
// Character priority scheduler
`timescale 1ns/10ps
`default_nettype none

module char_scheduler #(
	parameter int unsigned FCT_PEND_W = 3
)
(
	input logic pclk_tx,
	input logic enable_tx,
	input logic send_null_tx,
	input logic send_fct_tx,
	input logic send_fct_now,
	input spw_tx_pkg::data_char_t tx_data,
	input logic tx_data_valid,
	input spw_tx_pkg::byte_t tx_tcode,
	input logic tx_tcode_valid,
	output logic ready_tx_data,
	output logic ready_tx_timecode,
	char_if.scheduler ch
);
	import spw_tx_pkg::*;

	logic busy;
	logic boundary;
	logic run_mode;
	logic [FCT_PEND_W-1:0] fct_pend;
	logic fct_inc;
	logic fct_dec;
	char_kind_t data_kind;
	char_kind_t sel_kind;
	byte_t sel_payload;
	logic take_tcode;
	logic take_fct;
	logic take_data;

	// ------------------------------
	// Link mode and boundary
	// ------------------------------
	assign run_mode = send_null_tx & send_fct_tx;
	assign boundary = ~busy | ch.last_bit;

	// Mirrors the serializer being loaded
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			busy <= 1'b0;
		end
		else if (ch.load)
		begin
			busy <= 1'b1;
		end
		else if (ch.last_bit)
		begin
			busy <= 1'b0;
		end
	end

	// Control flag set means EOP or EEP
	assign data_kind = tx_data[8] ? ((tx_data[7:0] == 8'd0) ? KIND_EOP : KIND_EEP) : KIND_DATA;

	// ------------------------------
	// Priority selection
	// ------------------------------
	always_comb
	begin
		sel_kind = KIND_NULL;
		sel_payload = '0;
		take_tcode = 1'b0;
		take_fct = 1'b0;
		take_data = 1'b0;
		if (run_mode)
		begin
			if (tx_tcode_valid)
			begin
				sel_kind = KIND_TIME;
				sel_payload = tx_tcode;
				take_tcode = 1'b1;
			end
			else if (fct_pend != '0)
			begin
				sel_kind = KIND_FCT;
				take_fct = 1'b1;
			end
			else if (tx_data_valid)
			begin
				sel_kind = data_kind;
				sel_payload = tx_data[7:0];
				take_data = 1'b1;
			end
		end
	end

	// Nothing leaves while idle
	assign ch.load = boundary & send_null_tx;
	assign ch.kind = sel_kind;
	assign ch.payload = sel_payload;

	assign ready_tx_data = ch.load & take_data;
	assign ready_tx_timecode = ch.load & take_tcode;

	// ------------------------------
	// Pending FCT count
	// ------------------------------
	assign fct_inc = send_fct_now & (fct_pend != '1);
	assign fct_dec = ch.load & take_fct;

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			fct_pend <= '0;
		end
		else if (fct_inc && !fct_dec)
		begin
			fct_pend <= fct_pend + 1'b1;
		end
		else if (fct_dec && !fct_inc)
		begin
			fct_pend <= fct_pend - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- src/char_serializer.sv
// Character serializer with data-strobe output
`timescale 1ns/10ps
`default_nettype none

module char_serializer
(
	input logic pclk_tx,
	input logic enable_tx,
	char_if.serializer ch,
	output logic dout,
	output logic sout
);
	import spw_tx_pkg::*;

	logic active;
	bit_count_t remain;
	logic [LEN_TIME-2:0] shreg;
	logic par_prev;
	logic [LEN_TIME-1:0] seq;
	bit_count_t seq_len;
	logic seq_par;
	logic step;
	logic next_bit;

	// Odd parity over previous data bits, this flag and itself
	function automatic logic parity_bit(input logic prev, input logic flag);
		return ~(prev ^ flag);
	endfunction

	// Parity bit first, then the code bits
	function automatic logic [3:0] ctrl_seq(input logic [2:0] code, input logic par);
		return {code[0], code[1], code[2], par};
	endfunction

	// Two bits after the flag count as data
	function automatic logic code_par(input logic [2:0] code);
		return ^code[1:0];
	endfunction

	// ------------------------------
	// Bit sequence, lsb sent first
	// ------------------------------
	always_comb
	begin
		case (ch.kind)
			KIND_FCT:
			begin
				seq = {10'd0, ctrl_seq(FCT_BITS, parity_bit(par_prev, 1'b1))};
				seq_len = LEN_CTRL;
				seq_par = code_par(FCT_BITS);
			end
			KIND_EOP:
			begin
				seq = {10'd0, ctrl_seq(EOP_BITS, parity_bit(par_prev, 1'b1))};
				seq_len = LEN_CTRL;
				seq_par = code_par(EOP_BITS);
			end
			KIND_EEP:
			begin
				seq = {10'd0, ctrl_seq(EEP_BITS, parity_bit(par_prev, 1'b1))};
				seq_len = LEN_CTRL;
				seq_par = code_par(EEP_BITS);
			end
			KIND_DATA:
			begin
				seq = {4'd0, ch.payload, 1'b0, parity_bit(par_prev, 1'b0)};
				seq_len = LEN_DATA;
				seq_par = ^ch.payload;
			end
			KIND_TIME:
			begin
				seq = {ch.payload, 1'b0, parity_bit(code_par(ESC_BITS), 1'b0),
					ctrl_seq(ESC_BITS, parity_bit(par_prev, 1'b1))};
				seq_len = LEN_TIME;
				seq_par = ^ch.payload;
			end
			default:
			begin
				// NULL is ESC followed by FCT
				seq = {6'd0, ctrl_seq(FCT_BITS, parity_bit(code_par(ESC_BITS), 1'b1)),
					ctrl_seq(ESC_BITS, parity_bit(par_prev, 1'b1))};
				seq_len = LEN_NULL;
				seq_par = code_par(FCT_BITS);
			end
		endcase
	end

	assign ch.last_bit = active & (remain == '0);

	// New bit on each load or while bits remain
	assign step = ch.load | (active & (remain != '0));
	assign next_bit = ch.load ? seq[0] : shreg[0];

	// ------------------------------
	// Shift and line registers
	// ------------------------------
	always_ff @(posedge pclk_tx)
	begin
		if (ch.load)
		begin
			shreg <= seq[LEN_TIME-1:1];
		end
		else if (step)
		begin
			shreg <= shreg >> 1;
		end
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			active <= 1'b0;
			remain <= '0;
			par_prev <= 1'b0;
			dout <= 1'b0;
			sout <= 1'b0;
		end
		else
		begin
			if (ch.load)
			begin
				active <= 1'b1;
				remain <= seq_len - 4'd1;
				par_prev <= seq_par;
			end
			else if (step)
			begin
				remain <= remain - 4'd1;
			end
			else
			begin
				active <= 1'b0;
			end
			// Strobe toggles when data repeats
			if (step)
			begin
				dout <= next_bit;
				sout <= (next_bit == dout) ? ~sout : sout;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/spw_tx.sv
// SpaceWire character transmitter
`timescale 1ns/10ps
`default_nettype none

module spw_tx #(
	parameter int unsigned FCT_PEND_W = 3
)
(
	input logic pclk_tx,
	input logic enable_tx,
	input logic send_null_tx,
	input logic send_fct_tx,
	input logic send_fct_now,
	input spw_tx_pkg::data_char_t tx_data,
	input logic tx_data_valid,
	input spw_tx_pkg::byte_t tx_tcode,
	input logic tx_tcode_valid,
	output logic ready_tx_data,
	output logic ready_tx_timecode,
	output logic dout,
	output logic sout
);

	// Scheduler to serializer handoff
	char_if ch_bus ();

	// ------------------------------
	// Character selection
	// ------------------------------
	char_scheduler #(
		.FCT_PEND_W(FCT_PEND_W)
	) u_scheduler (
		.pclk_tx(pclk_tx),
		.enable_tx(enable_tx),
		.send_null_tx(send_null_tx),
		.send_fct_tx(send_fct_tx),
		.send_fct_now(send_fct_now),
		.tx_data(tx_data),
		.tx_data_valid(tx_data_valid),
		.tx_tcode(tx_tcode),
		.tx_tcode_valid(tx_tcode_valid),
		.ready_tx_data(ready_tx_data),
		.ready_tx_timecode(ready_tx_timecode),
		.ch(ch_bus.scheduler)
	);

	// ------------------------------
	// Serial line
	// ------------------------------
	char_serializer u_serializer (
		.pclk_tx(pclk_tx),
		.enable_tx(enable_tx),
		.ch(ch_bus.serializer),
		.dout(dout),
		.sout(sout)
	);

endmodule

`default_nettype wire

//--- src/spw_tx_pkg.sv
// SpaceWire transmitter definitions
`default_nettype none

package spw_tx_pkg;

	// ------------------------------
	// Character kinds and payloads
	// ------------------------------
	typedef enum logic [2:0]
	{
		KIND_NULL = 3'd0,
		KIND_FCT  = 3'd1,
		KIND_DATA = 3'd2,
		KIND_EOP  = 3'd3,
		KIND_EEP  = 3'd4,
		KIND_TIME = 3'd5
	} char_kind_t;

	// Bit 8 is the control flag, low byte selects EOP (zero) or EEP
	typedef logic [8:0] data_char_t;

	typedef logic [7:0] byte_t;

	// Wide enough to index the longest character
	typedef logic [3:0] bit_count_t;

	// ------------------------------
	// Control codes
	// ------------------------------
	// Bits after the parity bit, leftmost sent first
	localparam logic [2:0] ESC_BITS = 3'b111;
	localparam logic [2:0] FCT_BITS = 3'b100;
	localparam logic [2:0] EOP_BITS = 3'b110;
	localparam logic [2:0] EEP_BITS = 3'b101;

	// Bits on the wire per character kind
	localparam bit_count_t LEN_CTRL = 4'd4;
	localparam bit_count_t LEN_DATA = 4'd10;
	localparam bit_count_t LEN_NULL = 4'd8;
	localparam bit_count_t LEN_TIME = 4'd14;

endpackage

`default_nettype wire

//--- testbench/spw_tx_chk.sv
// Line and ready pulse assertions
`timescale 1ns/10ps
`default_nettype none

module spw_tx_chk
(
	input logic pclk_tx,
	input logic enable_tx,
	input logic send_null_tx,
	input logic ready_tx_data,
	input logic ready_tx_timecode,
	input logic dout,
	input logic sout
);

	// Link told to start at least once since reset
	logic link_started;

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			link_started <= 1'b0;
		end
		else if (send_null_tx)
		begin
			link_started <= 1'b1;
		end
	end

	// Data-strobe moves one wire per bit
	one_wire_moves: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		!((dout != $past(dout)) && (sout != $past(sout))))
		else $error("dout and sout changed in the same cycle");

	data_ready_single: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		ready_tx_data |=> !ready_tx_data)
		else $error("ready_tx_data held for more than one cycle");

	tcode_ready_single: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		ready_tx_timecode |=> !ready_tx_timecode)
		else $error("ready_tx_timecode held for more than one cycle");

	ready_exclusive: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		!(ready_tx_data && ready_tx_timecode))
		else $error("both ready pulses in one cycle");

	// Silent line until the first start
	idle_quiet: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		(!link_started && !send_null_tx) |->
		(!dout && !sout && !ready_tx_data && !ready_tx_timecode))
		else $error("line moved before the link was started");

endmodule

bind spw_tx spw_tx_chk u_chk
(
	.pclk_tx(pclk_tx),
	.enable_tx(enable_tx),
	.send_null_tx(send_null_tx),
	.ready_tx_data(ready_tx_data),
	.ready_tx_timecode(ready_tx_timecode),
	.dout(dout),
	.sout(sout)
);

`default_nettype wire

//--- testbench/spw_tx_tb.sv
// SpaceWire transmitter testbench
`timescale 1ns/10ps
`default_nettype none

module spw_tx_tb;
	import spw_tx_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 16;
	localparam int QUIET_CYCLES = 40;
	// Rough bit cycles per test including trailing NULLs
	localparam int TEST_CYCLES = QUIET_CYCLES + 7 * 8 + (4 * 4 + 3 * 8)
		+ (12 * 10 + 3 * 8) + (7 * 10 + 14 + 3 * 8);
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 * TEST_CYCLES + 200;

	logic pclk_tx;
	logic enable_tx;
	logic send_null_tx;
	logic send_fct_tx;
	logic send_fct_now;
	data_char_t tx_data;
	logic tx_data_valid;
	byte_t tx_tcode;
	logic tx_tcode_valid;
	logic ready_tx_data;
	logic ready_tx_timecode;
	logic dout;
	logic sout;

	integer seed;
	int errors;
	int start_errors;
	int tests_passed;
	int tests_failed;
	string test_name;
	int null_count;
	int data_ready_count;
	int tcode_ready_count;
	logic last_d;
	logic last_s;
	logic last_ready_data;
	logic last_ready_tcode;
	logic line_running;
	logic par_prev;
	logic [13:0] char_bits;
	int bit_num;
	// Expected non-NULL characters as {kind, value}
	logic [10:0] exp_q[$];

	spw_tx UUT (.*);

	always #(CLK_PERIOD / 2) pclk_tx = ~pclk_tx;

	// ------------------------------
	// Reference model
	// ------------------------------
	// Odd count over previous data bits, flag and parity bit
	function automatic logic odd_parity(input logic prev_data, input logic flag);
		return !(prev_data ^ flag);
	endfunction

	// Wire bits of one character with the first bit in bit 0
	function automatic logic [13:0] expected_bits(input char_kind_t kind, input byte_t value,
		input logic prev_data);
		logic [13:0] b;
		b = '0;
		b[0] = odd_parity(prev_data, kind != KIND_DATA);
		case (kind)
			KIND_DATA: b[9:1] = {value, 1'b0};
			KIND_FCT: b[3:1] = 3'b001;
			KIND_EOP: b[3:1] = 3'b011;
			KIND_EEP: b[3:1] = 3'b101;
			KIND_TIME:
			begin
				b[3:1] = 3'b111;
				b[4] = odd_parity(1'b0, 1'b0);
				b[13:5] = {value, 1'b0};
			end
			default:
			begin
				b[3:1] = 3'b111;
				b[4] = odd_parity(1'b0, 1'b1);
				b[7:5] = 3'b001;
			end
		endcase
		return b;
	endfunction

	// Parity of the data bits a character leaves behind
	function automatic logic data_bits_parity(input char_kind_t kind, input byte_t value);
		case (kind)
			KIND_DATA, KIND_TIME: return ^value;
			KIND_EOP, KIND_EEP: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [10:0] expected_entry(input data_char_t item);
		if (!item[8])
			return {KIND_DATA, item[7:0]};
		else if (item[7:0] == 8'd0)
			return {KIND_EOP, 8'd0};
		else
			return {KIND_EEP, 8'd0};
	endfunction

	// ------------------------------
	// Decoder
	// ------------------------------
	// Zero while the header is still incomplete
	function automatic int char_length(input logic [13:0] b, input int n);
		if (n < 2)
			return 0;
		if (!b[1])
			return 10;
		if (n < 4)
			return 0;
		if (b[3:2] != 2'b11)
			return 4;
		if (n < 6)
			return 0;
		return b[5] ? 8 : 14;
	endfunction

	function automatic char_kind_t decoded_kind(input logic [13:0] b, input int n);
		if (n == 10)
			return KIND_DATA;
		if (n == 8)
			return KIND_NULL;
		if (n == 14)
			return KIND_TIME;
		case (b[3:2])
			2'b01: return KIND_EOP;
			2'b10: return KIND_EEP;
			default: return KIND_FCT;
		endcase
	endfunction

	task automatic take_bit(input logic b);
		int len;
		char_kind_t kind;
		byte_t value;
		logic [13:0] mask;
		logic [13:0] exp_bits;
		logic [10:0] exp_char;
		char_bits[bit_num] = b;
		bit_num++;
		len = char_length(char_bits, bit_num);
		if (len != 0 && bit_num == len)
		begin
			kind = decoded_kind(char_bits, len);
			value = (len == 10) ? char_bits[9:2] : (len == 14) ? char_bits[13:6] : 8'd0;
			mask = (14'd1 << len) - 14'd1;
			exp_bits = expected_bits(kind, value, par_prev);
			if ((char_bits & mask) != exp_bits)
			begin
				$display("** Error %s: bits expected %h, actual %h", test_name, exp_bits,
					char_bits & mask);
				errors++;
			end
			par_prev = data_bits_parity(kind, value);
			if (kind == KIND_NULL)
				null_count++;
			else if (exp_q.size() == 0)
			begin
				$display("%s: unexpected character %h on the line", test_name, {kind, value});
				errors++;
			end
			else
			begin
				exp_char = exp_q.pop_front();
				if (exp_char != {kind, value})
				begin
					$display("** Error %s: character expected %h, actual %h", test_name,
						exp_char, {kind, value});
					errors++;
				end
			end
			char_bits = '0;
			bit_num = 0;
		end
	endtask

	// Sample a quarter period before the rising edge
	always @(negedge pclk_tx)
	begin
		#(CLK_PERIOD / 4);
		if (ready_tx_data && ready_tx_timecode)
		begin
			$display("%s: both ready pulses in one cycle", test_name);
			errors++;
		end
		if ((ready_tx_data && last_ready_data) || (ready_tx_timecode && last_ready_tcode))
		begin
			$display("%s: ready pulse longer than one cycle", test_name);
			errors++;
		end
		data_ready_count += ready_tx_data;
		tcode_ready_count += ready_tx_timecode;
		if (dout != last_d && sout != last_s)
		begin
			$display("%s: dout and sout changed together", test_name);
			errors++;
		end
		else if ((dout ^ sout) != (last_d ^ last_s))
		begin
			take_bit(dout);
			line_running = 1'b1;
		end
		// A started line carries a bit in every cycle
		else if (line_running && send_null_tx)
		begin
			$display("%s: no bit on the line in a bit cycle", test_name);
			errors++;
		end
		last_d = dout;
		last_s = sout;
		last_ready_data = ready_tx_data;
		last_ready_tcode = ready_tx_timecode;
	end

	// ------------------------------
	// Stimulus helpers
	// ------------------------------
	task automatic start_test(input string name);
		test_name = name;
		start_errors = errors;
	endtask

	task automatic report_test();
		if (errors == start_errors)
		begin
			$display("%s: passed", test_name);
			tests_passed++;
		end
		else
		begin
			$display("%s: failed with %0d errors", test_name, errors - start_errors);
			tests_failed++;
		end
	endtask

	task automatic check_count(input string what, input int actual, input int expected);
		if (actual != expected)
		begin
			$display("** Error %s: %s expected %0d, actual %0d", test_name, what, expected,
				actual);
			errors++;
		end
	endtask

	// Wait for an empty queue and two more NULLs to catch stray characters
	task automatic wait_drained();
		int target;
		while (exp_q.size() != 0)
			@(negedge pclk_tx);
		target = null_count + 2;
		while (null_count < target)
			@(negedge pclk_tx);
	endtask

	task automatic send_data(input data_char_t item);
		@(negedge pclk_tx);
		tx_data = item;
		tx_data_valid = 1'b1;
		exp_q.push_back(expected_entry(item));
		#(CLK_PERIOD / 4);
		while (!ready_tx_data)
		begin
			@(negedge pclk_tx);
			#(CLK_PERIOD / 4);
		end
	endtask

	// Time code raised together with the next data item
	task automatic send_with_tcode(input data_char_t item, input byte_t tval);
		@(negedge pclk_tx);
		tx_data = item;
		tx_data_valid = 1'b1;
		tx_tcode = tval;
		tx_tcode_valid = 1'b1;
		exp_q.push_back({KIND_TIME, tval});
		exp_q.push_back(expected_entry(item));
		#(CLK_PERIOD / 4);
		while (!ready_tx_timecode)
		begin
			if (ready_tx_data)
			begin
				$display("%s: data taken ahead of the time code", test_name);
				errors++;
			end
			@(negedge pclk_tx);
			#(CLK_PERIOD / 4);
		end
		@(negedge pclk_tx);
		tx_tcode_valid = 1'b0;
		#(CLK_PERIOD / 4);
		while (!ready_tx_data)
		begin
			@(negedge pclk_tx);
			#(CLK_PERIOD / 4);
		end
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial
	begin
		int i;
		logic [31:0] r;
		int data_start;
		int tcode_start;
		seed = 32'hae6;
		pclk_tx = 1'b0;
		enable_tx = 1'b0;
		send_null_tx = 1'b0;
		send_fct_tx = 1'b0;
		send_fct_now = 1'b0;
		tx_data = '0;
		tx_data_valid = 1'b0;
		tx_tcode = '0;
		tx_tcode_valid = 1'b0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		test_name = "reset";
		null_count = 0;
		data_ready_count = 0;
		tcode_ready_count = 0;
		last_d = 1'b0;
		last_s = 1'b0;
		last_ready_data = 1'b0;
		last_ready_tcode = 1'b0;
		line_running = 1'b0;
		par_prev = 1'b0;
		char_bits = '0;
		bit_num = 0;
		repeat (RESET_CYCLES) @(negedge pclk_tx);
		enable_tx = 1'b1;

		start_test("idle_after_reset");
		repeat (QUIET_CYCLES)
		begin
			@(negedge pclk_tx);
			#(CLK_PERIOD / 4);
			if (dout !== 1'b0 || sout !== 1'b0 || ready_tx_data || ready_tx_timecode)
			begin
				$display("%s: line moved while the link is idle", test_name);
				errors++;
			end
		end
		report_test();

		start_test("null_stream");
		@(negedge pclk_tx);
		send_null_tx = 1'b1;
		while (null_count < 5)
			@(negedge pclk_tx);
		report_test();

		start_test("fct_requests");
		@(negedge pclk_tx);
		send_fct_tx = 1'b1;
		repeat (3)
		begin
			@(negedge pclk_tx);
			send_fct_now = 1'b1;
			exp_q.push_back({KIND_FCT, 8'h00});
			@(negedge pclk_tx);
			send_fct_now = 1'b0;
		end
		wait_drained();
		report_test();

		start_test("data_packets");
		data_start = data_ready_count;
		for (i = 0; i < 12; i++)
		begin
			r = $random(seed);
			if (i == 5)
				send_data(9'h100);
			else if (i == 11)
				send_data({1'b1, r[7:0] | 8'h01});
			else
				send_data({1'b0, r[7:0]});
		end
		@(negedge pclk_tx);
		tx_data_valid = 1'b0;
		wait_drained();
		check_count("data ready pulses", data_ready_count - data_start, 12);
		report_test();

		start_test("time_code");
		data_start = data_ready_count;
		tcode_start = tcode_ready_count;
		for (i = 0; i < 7; i++)
		begin
			r = $random(seed);
			if (i == 3)
				send_with_tcode({1'b0, r[7:0]}, r[15:8]);
			else
				send_data({1'b0, r[7:0]});
		end
		@(negedge pclk_tx);
		tx_data_valid = 1'b0;
		wait_drained();
		check_count("data ready pulses", data_ready_count - data_start, 7);
		check_count("time code ready pulses", tcode_ready_count - tcode_start, 1);
		report_test();

		$display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
			errors);
		if (errors == 0 && tests_failed == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge pclk_tx);
		$display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire
